// File: rtl/core_pkg.sv
// Core types and pipeline payloads
`default_nettype none

package core_pkg;

    localparam int xlen    = 32;
    localparam int nregs   = 32;
    localparam int shamt_w = $clog2(xlen);

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    localparam xlen_t reset_pc = '0;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        xlen_t       pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     op_a;
        xlen_t     op_b;       // rs2 value or immediate
        xlen_t     imm;        // branch and jump offset
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      rd_we;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      is_ebreak;
    } id_ex_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     result;
        reg_addr_t rd;
        logic      rd_we;
        logic      is_ebreak;
    } ex_mem_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     result;
        reg_addr_t rd;
        logic      rd_we;
        logic      is_ebreak;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rtl/core_top.sv
// Five-stage RV32I core
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic          clk,
    input  wire logic          reset_i,
    output core_pkg::xlen_t     imem_addr_o,
    input  wire logic [31:0]    imem_data_i,
    output logic                retire_valid_o,
    output core_pkg::xlen_t     retire_pc_o,
    output core_pkg::reg_addr_t retire_rd_o,
    output logic                retire_we_o,
    output core_pkg::xlen_t     retire_data_o,
    output logic                halt_o
);

    logic              fe_valid;
    core_pkg::if_id_t  fe_out;
    core_pkg::if_id_t  id_in;
    logic              id_valid;
    core_pkg::id_ex_t  id_out;
    core_pkg::id_ex_t  ex_in;
    logic              ex_valid;
    core_pkg::ex_mem_t ex_out;
    core_pkg::ex_mem_t mem_in;
    logic              mem_valid;
    core_pkg::mem_wb_t mem_out;
    core_pkg::mem_wb_t wb_in;
    logic              wb_valid;
    logic              redirect;
    core_pkg::xlen_t   target;
    logic              halt_q;
    logic              halt_set;

    writeback_if wb_bus ();

    fetch_stage u_fetch (
        .clk,
        .reset_i,
        .halt_i     (halt_q),
        .redirect_i (redirect),
        .target_i   (target),
        .pc_o       (imem_addr_o),
        .valid_o    (fe_valid)
    );

    assign fe_out = '{pc: imem_addr_o, instr: imem_data_i};

    // front registers drop the two shadow slots of a taken transfer
    pipe_reg #(.payload_t(core_pkg::if_id_t)) u_if_id (
        .clk, .reset_i, .stall_i(halt_q), .flush_i(redirect || halt_set),
        .valid_i(fe_valid), .data_i(fe_out), .valid_o(id_valid), .data_o(id_in)
    );

    decode_stage u_decode (
        .clk,
        .reset_i,
        .in_i            (id_in),
        .in_valid_i      (id_valid),
        .fwd_exm_i       (ex_out),
        .fwd_exm_valid_i (ex_valid),
        .fwd_mwb_i       (mem_out),
        .fwd_mwb_valid_i (mem_valid),
        .wb              (wb_bus),
        .out_o           (id_out)
    );

    pipe_reg #(.payload_t(core_pkg::id_ex_t)) u_id_ex (
        .clk, .reset_i, .stall_i(halt_q), .flush_i(redirect || halt_set),
        .valid_i(id_valid), .data_i(id_out), .valid_o(ex_valid), .data_o(ex_in)
    );

    execute_stage u_execute (
        .in_i       (ex_in),
        .in_valid_i (ex_valid),
        .out_o      (ex_out),
        .redirect_o (redirect),
        .target_o   (target)
    );

    pipe_reg #(.payload_t(core_pkg::ex_mem_t)) u_ex_mem (
        .clk, .reset_i, .stall_i(halt_q), .flush_i(halt_set),
        .valid_i(ex_valid), .data_i(ex_out), .valid_o(mem_valid), .data_o(mem_in)
    );

    // memory stage only carries the result on
    assign mem_out = '{pc: mem_in.pc, result: mem_in.result, rd: mem_in.rd,
                       rd_we: mem_in.rd_we, is_ebreak: mem_in.is_ebreak};

    pipe_reg #(.payload_t(core_pkg::mem_wb_t)) u_mem_wb (
        .clk, .reset_i, .stall_i(halt_q), .flush_i(halt_set),
        .valid_i(mem_valid), .data_i(mem_out), .valid_o(wb_valid), .data_o(wb_in)
    );

    assign wb_bus.valid = wb_valid;
    assign wb_bus.pc    = wb_in.pc;
    assign wb_bus.rd    = wb_in.rd;
    assign wb_bus.rd_we = wb_valid && wb_in.rd_we;
    assign wb_bus.data  = wb_in.result;

    assign halt_set = wb_valid && wb_in.is_ebreak;  // ebreak retiring, kill younger

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_q <= 1'b0;
        end else if (halt_set) begin
            halt_q <= 1'b1;  // sticky
        end
    end

    assign halt_o         = halt_q;
    assign retire_valid_o = wb_bus.valid;
    assign retire_pc_o    = wb_bus.pc;
    assign retire_rd_o    = wb_bus.rd;
    assign retire_we_o    = wb_bus.rd_we;
    assign retire_data_o  = wb_bus.data;

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// Instruction decode and operand read
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire core_pkg::if_id_t  in_i,
    input  wire logic              in_valid_i,
    input  wire core_pkg::ex_mem_t fwd_exm_i,
    input  wire logic              fwd_exm_valid_i,
    input  wire core_pkg::mem_wb_t fwd_mwb_i,
    input  wire logic              fwd_mwb_valid_i,
    writeback_if.sink              wb,
    output core_pkg::id_ex_t       out_o
);

    logic [rv_isa_pkg::opcode_w-1:0] opcode;
    logic [rv_isa_pkg::funct3_w-1:0] funct3;
    logic [rv_isa_pkg::funct7_w-1:0] funct7;
    core_pkg::reg_addr_t             rs1;
    core_pkg::reg_addr_t             rs2;
    core_pkg::reg_addr_t             rd;
    core_pkg::xlen_t                 imm_i;
    core_pkg::xlen_t                 imm_b;
    core_pkg::xlen_t                 imm_j;
    core_pkg::xlen_t                 imm_u;
    core_pkg::xlen_t                 imm;
    core_pkg::xlen_t                 rf_rs1;
    core_pkg::xlen_t                 rf_rs2;
    core_pkg::alu_op_e               alu_op;
    logic                            writes;
    logic                            use_imm;
    logic                            is_branch;
    logic                            branch_ne;
    logic                            is_jal;
    logic                            is_ebreak;

    assign opcode = in_i.instr[6:0];
    assign rd     = in_i.instr[11:7];
    assign funct3 = in_i.instr[14:12];
    assign rs1    = in_i.instr[19:15];
    assign rs2    = in_i.instr[24:20];
    assign funct7 = in_i.instr[31:25];

    assign imm_i = {{20{in_i.instr[31]}}, in_i.instr[31:20]};
    assign imm_b = {{19{in_i.instr[31]}}, in_i.instr[31], in_i.instr[7],
                    in_i.instr[30:25], in_i.instr[11:8], 1'b0};
    assign imm_j = {{11{in_i.instr[31]}}, in_i.instr[31], in_i.instr[19:12],
                    in_i.instr[20], in_i.instr[30:21], 1'b0};
    assign imm_u = {in_i.instr[31:12], 12'b0};

    reg_file u_reg_file (
        .clk,
        .reset_i,
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2),
        .wb         (wb)
    );

    // youngest producer wins, then the register file
    function automatic core_pkg::xlen_t forward(core_pkg::reg_addr_t rs,
                                                core_pkg::xlen_t rf_val);
        if (fwd_exm_valid_i && fwd_exm_i.rd_we && (fwd_exm_i.rd == rs)) begin
            return fwd_exm_i.result;
        end
        if (fwd_mwb_valid_i && fwd_mwb_i.rd_we && (fwd_mwb_i.rd == rs)) begin
            return fwd_mwb_i.result;
        end
        return rf_val;
    endfunction

    always_comb begin
        writes    = 1'b0;
        use_imm   = 1'b0;
        imm       = imm_i;
        alu_op    = core_pkg::alu_add;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        is_ebreak = 1'b0;
        case (opcode)
            rv_isa_pkg::opc_lui: begin
                writes  = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = core_pkg::alu_pass_b;
            end
            rv_isa_pkg::opc_op_imm: begin
                writes  = 1'b1;
                use_imm = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_add: alu_op = core_pkg::alu_add;
                    rv_isa_pkg::f3_slt: alu_op = core_pkg::alu_slt;
                    rv_isa_pkg::f3_xor: alu_op = core_pkg::alu_xor;
                    rv_isa_pkg::f3_or:  alu_op = core_pkg::alu_or;
                    rv_isa_pkg::f3_and: alu_op = core_pkg::alu_and;
                    default:            writes = 1'b0;  // shifts by immediate, sltiu
                endcase
            end
            rv_isa_pkg::opc_op: begin
                if (funct7 == '0) begin
                    writes = 1'b1;
                    case (funct3)
                        rv_isa_pkg::f3_add: alu_op = core_pkg::alu_add;
                        rv_isa_pkg::f3_sll: alu_op = core_pkg::alu_sll;
                        rv_isa_pkg::f3_slt: alu_op = core_pkg::alu_slt;
                        rv_isa_pkg::f3_xor: alu_op = core_pkg::alu_xor;
                        rv_isa_pkg::f3_sr:  alu_op = core_pkg::alu_srl;
                        rv_isa_pkg::f3_or:  alu_op = core_pkg::alu_or;
                        rv_isa_pkg::f3_and: alu_op = core_pkg::alu_and;
                        default:            writes = 1'b0;  // sltu
                    endcase
                end else if (funct7 == rv_isa_pkg::f7_alt) begin
                    writes = (funct3 == rv_isa_pkg::f3_add) || (funct3 == rv_isa_pkg::f3_sr);
                    alu_op = (funct3 == rv_isa_pkg::f3_sr) ? core_pkg::alu_sra
                                                           : core_pkg::alu_sub;
                end
            end
            rv_isa_pkg::opc_branch: begin
                imm       = imm_b;
                is_branch = (funct3 == rv_isa_pkg::f3_beq) || (funct3 == rv_isa_pkg::f3_bne);
                branch_ne = (funct3 == rv_isa_pkg::f3_bne);
            end
            rv_isa_pkg::opc_jal: begin
                writes = 1'b1;
                imm    = imm_j;
                is_jal = 1'b1;
            end
            rv_isa_pkg::opc_system: is_ebreak = (in_i.instr == rv_isa_pkg::ebreak_word);
            default: writes = 1'b0;  // retires as a no-op
        endcase
    end

    always_comb begin
        out_o.pc        = in_i.pc;
        out_o.op_a      = forward(rs1, rf_rs1);
        out_o.op_b      = use_imm ? imm : forward(rs2, rf_rs2);
        out_o.imm       = imm;
        out_o.alu_op    = alu_op;
        out_o.rd        = rd;
        out_o.rd_we     = in_valid_i && writes && (rd != '0);  // x0 writes dropped
        out_o.is_branch = is_branch;
        out_o.branch_ne = branch_ne;
        out_o.is_jal    = is_jal;
        out_o.is_ebreak = is_ebreak;
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// ALU and branch resolution
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire core_pkg::id_ex_t in_i,
    input  wire logic             in_valid_i,
    output core_pkg::ex_mem_t     out_o,
    output logic                  redirect_o,
    output core_pkg::xlen_t       target_o
);

    core_pkg::xlen_t                a;
    core_pkg::xlen_t                b;
    core_pkg::xlen_t                alu_res;
    logic [core_pkg::shamt_w-1:0]   shamt;
    logic                           taken;

    assign a     = in_i.op_a;
    assign b     = in_i.op_b;
    assign shamt = b[core_pkg::shamt_w-1:0];

    always_comb begin
        case (in_i.alu_op)
            core_pkg::alu_add:    alu_res = a + b;
            core_pkg::alu_sub:    alu_res = a - b;
            core_pkg::alu_sll:    alu_res = a << shamt;
            core_pkg::alu_slt:    alu_res = core_pkg::xlen_t'($signed(a) < $signed(b));
            core_pkg::alu_xor:    alu_res = a ^ b;
            core_pkg::alu_srl:    alu_res = a >> shamt;
            core_pkg::alu_sra:    alu_res = core_pkg::xlen_t'($signed(a) >>> shamt);
            core_pkg::alu_or:     alu_res = a | b;
            core_pkg::alu_and:    alu_res = a & b;
            core_pkg::alu_pass_b: alu_res = b;  // lui
            default:              alu_res = '0;
        endcase
    end

    assign taken      = in_i.is_branch && ((a == b) != in_i.branch_ne);
    assign redirect_o = in_valid_i && (taken || in_i.is_jal);
    assign target_o   = in_i.pc + in_i.imm;

    always_comb begin
        out_o.pc        = in_i.pc;
        out_o.result    = in_i.is_jal ? in_i.pc + core_pkg::xlen_t'(4) : alu_res;  // link
        out_o.rd        = in_i.rd;
        out_o.rd_we     = in_i.rd_we;
        out_o.is_ebreak = in_i.is_ebreak;
    end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// Instruction fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            halt_i,
    input  wire logic            redirect_i,
    input  wire core_pkg::xlen_t target_i,
    output core_pkg::xlen_t      pc_o,
    output logic                 valid_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= core_pkg::reset_pc;
        end else if (halt_i) begin
            pc_o <= pc_o;  // frozen until reset
        end else if (redirect_i) begin
            pc_o <= target_i;
        end else begin
            pc_o <= pc_o + core_pkg::xlen_t'(4);
        end
    end

    assign valid_o = !halt_i;  // nothing issued once halted

endmodule

`default_nettype wire

// File: rtl/pipe_reg.sv
// Pipeline boundary register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     stall_i,
    input  wire logic     flush_i,
    input  wire logic     valid_i,
    input  wire payload_t data_i,
    output logic          valid_o,
    output payload_t      data_o
);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_o <= 1'b0;  // bubble
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire core_pkg::reg_addr_t rs1_i,
    input  wire core_pkg::reg_addr_t rs2_i,
    output core_pkg::xlen_t          rs1_data_o,
    output core_pkg::xlen_t          rs2_data_o,
    writeback_if.sink                wb
);

    core_pkg::xlen_t regs [1:core_pkg::nregs-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < core_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd_we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is seen by the reader
    function automatic core_pkg::xlen_t read_port(core_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.valid && wb.rd_we && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
// RV32I encoding constants
`default_nettype none

package rv_isa_pkg;

    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;

    // major opcodes of the supported subset
    localparam logic [opcode_w-1:0] opc_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] opc_op_imm = 7'b0010011;
    localparam logic [opcode_w-1:0] opc_op     = 7'b0110011;
    localparam logic [opcode_w-1:0] opc_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] opc_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] opc_system = 7'b1110011;

    localparam logic [funct3_w-1:0] f3_add = 3'b000;  // also addi, sub
    localparam logic [funct3_w-1:0] f3_sll = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt = 3'b010;  // also slti
    localparam logic [funct3_w-1:0] f3_xor = 3'b100;
    localparam logic [funct3_w-1:0] f3_sr  = 3'b101;  // srl and sra
    localparam logic [funct3_w-1:0] f3_or  = 3'b110;
    localparam logic [funct3_w-1:0] f3_and = 3'b111;
    localparam logic [funct3_w-1:0] f3_beq = 3'b000;
    localparam logic [funct3_w-1:0] f3_bne = 3'b001;

    localparam logic [funct7_w-1:0] f7_alt = 7'b0100000;  // sub, sra

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

endpackage

`default_nettype wire

// File: rtl/writeback_if.sv
// Writeback bus
`timescale 1ns/1ps
`default_nettype none

interface writeback_if;

    logic                valid;
    core_pkg::xlen_t     pc;
    core_pkg::reg_addr_t rd;
    logic                rd_we;  // already qualified by valid
    core_pkg::xlen_t     data;

    modport source (
        output valid, pc, rd, rd_we, data
    );

    modport sink (
        input valid, pc, rd, rd_we, data
    );

endinterface

`default_nettype wire

// File: sources.f
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/writeback_if.sv
rtl/pipe_reg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/core_top.sv
tb/core_asserts.sv
tb/core_tb.sv

// File: tb/core_asserts.sv
// Core interface assertions
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
    input wire logic                clk,
    input wire logic                reset_i,
    input wire core_pkg::xlen_t     imem_addr_i,
    input wire logic                retire_valid_i,
    input wire core_pkg::reg_addr_t retire_rd_i,
    input wire logic                retire_we_i,
    input wire core_pkg::xlen_t     retire_data_i,
    input wire logic                halt_i
);

    int fail_count = 0;  // failed assertions so far

    no_retire_in_reset: assert property (@(posedge clk) reset_i |=> !retire_valid_i)
        else begin
            fail_count++;
            $error("retire_valid_o high in the cycle after a reset edge");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (reset_i) halt_i |=> halt_i)
        else begin
            fail_count++;
            $error("halt_o fell outside reset");
        end

    // x0 never shows up as a real write
    we_rd_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        retire_we_i |-> (retire_rd_i != '0) || (retire_data_i == '0))
        else begin
            fail_count++;
            $error("retire_we_o set for x0 with nonzero data");
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        imem_addr_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("imem_addr_o not word aligned");
        end

endmodule

bind core_top core_asserts u_asserts (
    .clk            (clk),
    .reset_i        (reset_i),
    .imem_addr_i    (imem_addr_o),
    .retire_valid_i (retire_valid_o),
    .retire_rd_i    (retire_rd_o),
    .retire_we_i    (retire_we_o),
    .retire_data_i  (retire_data_o),
    .halt_i         (halt_o)
);

`default_nettype wire

// File: tb/core_tb.sv
// Pipelined core testbench
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int max_words = 64;
    localparam int max_rows  = 32;

    logic                clk;
    logic                reset_i;
    core_pkg::xlen_t     imem_addr;
    logic [31:0]         imem_data;
    logic                retire_valid;
    core_pkg::xlen_t     retire_pc;
    core_pkg::reg_addr_t retire_rd;
    logic                retire_we;
    core_pkg::xlen_t     retire_data;
    logic                halt;

    logic [31:0]         prog [0:max_words-1];
    string               exp_name [0:max_rows-1];
    core_pkg::xlen_t     exp_pc [0:max_rows-1];
    logic                exp_has_rd [0:max_rows-1];  // branches and ebreak have no rd
    core_pkg::reg_addr_t exp_rd [0:max_rows-1];
    logic                exp_we [0:max_rows-1];
    core_pkg::xlen_t     exp_data [0:max_rows-1];
    int                  prog_len;
    int                  n_exp;
    int                  n_seen;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  limit;
    int                  retire_cycle;

    core_top dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_we_o    (retire_we),
        .retire_data_o  (retire_data),
        .halt_o         (halt)
    );

    always #50 clk = ~clk;

    // past the program everything reads as ebreak
    assign imem_data = (imem_addr[31:2] < prog_len) ? prog[imem_addr[31:2]]
                                                    : rv_isa_pkg::ebreak_word;

    function automatic logic [31:0] i_format(logic [2:0] f3, core_pkg::reg_addr_t rd,
                                             core_pkg::reg_addr_t rs1, core_pkg::xlen_t imm);
        return {imm[11:0], rs1, f3, rd, rv_isa_pkg::opc_op_imm};
    endfunction

    function automatic logic [31:0] r_format(logic alt, logic [2:0] f3, core_pkg::reg_addr_t rd,
                                             core_pkg::reg_addr_t rs1, core_pkg::reg_addr_t rs2);
        return {(alt ? rv_isa_pkg::f7_alt : 7'b0), rs2, rs1, f3, rd, rv_isa_pkg::opc_op};
    endfunction

    function automatic logic [31:0] b_format(logic [2:0] f3, core_pkg::reg_addr_t rs1,
                                             core_pkg::reg_addr_t rs2, core_pkg::xlen_t imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] j_format(core_pkg::reg_addr_t rd, core_pkg::xlen_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::opc_jal};
    endfunction

    function automatic logic [31:0] u_format(core_pkg::reg_addr_t rd, logic [19:0] upper);
        return {upper, rd, rv_isa_pkg::opc_lui};
    endfunction

    task automatic place_word(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic add_row(input logic [31:0] word, input string name, input logic has_rd,
                           input core_pkg::reg_addr_t rd, input logic we,
                           input core_pkg::xlen_t data);
        exp_name[n_exp]   = name;
        exp_pc[n_exp]     = core_pkg::xlen_t'(prog_len * 4);  // straight-line order
        exp_has_rd[n_exp] = has_rd;
        exp_rd[n_exp]     = rd;
        exp_we[n_exp]     = we;
        exp_data[n_exp]   = data;
        n_exp++;
        place_word(word);
    endtask

    task automatic load_program();
        add_row(i_format(rv_isa_pkg::f3_add, 1, 0, 5), "addi pos", 1, 1, 1, 32'd5);
        add_row(i_format(rv_isa_pkg::f3_add, 2, 0, -3), "addi neg", 1, 2, 1, 32'hffff_fffd);
        add_row(i_format(rv_isa_pkg::f3_slt, 3, 2, 1), "slti true", 1, 3, 1, 32'd1);
        add_row(i_format(rv_isa_pkg::f3_slt, 4, 1, 2), "slti false", 1, 4, 1, 32'd0);
        add_row(i_format(rv_isa_pkg::f3_xor, 5, 1, -1), "xori", 1, 5, 1, 32'hffff_fffa);
        add_row(i_format(rv_isa_pkg::f3_or, 6, 1, 32'h0f0), "ori", 1, 6, 1, 32'h0000_00f5);
        add_row(i_format(rv_isa_pkg::f3_and, 7, 6, 32'h03c), "andi", 1, 7, 1, 32'h0000_0034);
        add_row(u_format(8, 20'h12345), "lui", 1, 8, 1, 32'h1234_5000);
        add_row(r_format(1'b0, rv_isa_pkg::f3_add, 9, 8, 1), "add", 1, 9, 1, 32'h1234_5005);
        add_row(r_format(1'b1, rv_isa_pkg::f3_add, 10, 9, 1), "sub", 1, 10, 1, 32'h1234_5000);
        add_row(r_format(1'b0, rv_isa_pkg::f3_sll, 11, 9, 1), "sll", 1, 11, 1, 32'h468a_00a0);
        add_row(r_format(1'b0, rv_isa_pkg::f3_sr, 12, 9, 3), "srl", 1, 12, 1, 32'h091a_2802);
        add_row(r_format(1'b1, rv_isa_pkg::f3_sr, 13, 5, 3), "sra", 1, 13, 1, 32'hffff_fffd);
        add_row(r_format(1'b0, rv_isa_pkg::f3_slt, 14, 13, 12), "slt", 1, 14, 1, 32'd1);
        add_row(r_format(1'b0, rv_isa_pkg::f3_xor, 15, 14, 13), "xor", 1, 15, 1, 32'hffff_fffc);
        add_row(r_format(1'b0, rv_isa_pkg::f3_or, 16, 15, 14), "or", 1, 16, 1, 32'hffff_fffd);
        add_row(r_format(1'b0, rv_isa_pkg::f3_and, 17, 16, 12), "and", 1, 17, 1, 32'h091a_2800);
        add_row(i_format(rv_isa_pkg::f3_add, 0, 1, 7), "x0 write", 1, 0, 0, 32'd0);
        add_row(r_format(1'b0, rv_isa_pkg::f3_add, 18, 0, 1), "x0 read", 1, 18, 1, 32'd5);
        add_row(b_format(rv_isa_pkg::f3_beq, 1, 18, 12), "beq taken", 0, 0, 0, 32'd0);
        place_word(i_format(rv_isa_pkg::f3_add, 19, 0, 1));  // beq shadow
        place_word(i_format(rv_isa_pkg::f3_add, 19, 0, 2));
        add_row(b_format(rv_isa_pkg::f3_bne, 1, 18, 8), "bne not taken", 0, 0, 0, 32'd0);
        add_row(j_format(20, 12), "jal", 1, 20, 1, 32'd96);
        place_word(i_format(rv_isa_pkg::f3_add, 21, 0, 1));  // jal shadow
        place_word(i_format(rv_isa_pkg::f3_add, 21, 0, 2));
        add_row(r_format(1'b0, rv_isa_pkg::f3_add, 22, 20, 1), "after jal", 1, 22, 1, 32'd101);
        add_row(rv_isa_pkg::ebreak_word, "ebreak", 0, 0, 0, 32'd0);
    endtask

    task automatic check_word(input string name, input string field,
                              input core_pkg::xlen_t exp, input core_pkg::xlen_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_addr_t exp,
                             input core_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s rd: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input string field,
                                input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", name, field, exp, act);
        end
    endtask

    task automatic score_retirement();
        if (n_seen >= n_exp) begin
            errors++;
            $display("unexpected retirement at pc %h after the expected stream", retire_pc);
        end else begin
            check_word(exp_name[n_seen], "pc", exp_pc[n_seen], retire_pc);
            compare_flag(exp_name[n_seen], "we", exp_we[n_seen], retire_we);
            if (exp_has_rd[n_seen]) begin
                check_reg(exp_name[n_seen], exp_rd[n_seen], retire_rd);
            end
            if (exp_we[n_seen]) begin
                check_word(exp_name[n_seen], "data", exp_data[n_seen], retire_data);
            end
        end
        n_seen++;
    endtask

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        prog_len     = 0;
        n_exp        = 0;
        n_seen       = 0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        retire_cycle = 0;
        load_program();
        limit = 8 * prog_len + 40;
        repeat (4) @(posedge clk);
        #1 reset_i = 1'b0;
        check_word("reset", "imem_addr", core_pkg::reset_pc, imem_addr);
        compare_flag("reset", "halt", 1'b0, halt);
        compare_flag("reset", "retire_valid", 1'b0, retire_valid);
        while (!halt && cycles < limit) begin
            @(negedge clk);  // outputs settled mid-cycle
            cycles++;
            if (retire_valid) begin
                score_retirement();
                retire_cycle = cycles;
            end
        end
        if (!halt) begin
            errors++;
            $display("timeout: halt_o did not rise within %0d cycles", limit);
        end else if (cycles != retire_cycle + 1) begin
            errors++;
            $display("halt_o did not rise in the cycle after the last retirement");
        end
        if (n_seen < n_exp) begin
            errors++;
            $display("only %0d of %0d expected retirements were seen", n_seen, n_exp);
        end
        while (cycles < limit) begin  // pipeline stays quiet while halted
            @(negedge clk);
            cycles++;
            if (retire_valid) begin
                errors++;
                $display("retirement at pc %h after halt", retire_pc);
            end
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_asserts.fail_count);
        if (errors == 0 && dut.u_asserts.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
